// ==== Bender.yml ====
package:
  name: irq_sleep_ctrl

sources:
  - source/irq_sleep_pkg.sv
  - source/irq_pending_reg.sv
  - source/irq_prio_arb.sv
  - source/obi_outstanding_cnt.sv
  - source/wfi_sleep_fsm.sv
  - source/irq_sleep_ctrl.sv
  - target: test
    files:
      - verif/irq_sleep_ctrl_asserts.sv
      - verif/tb_irq_sleep_ctrl.sv

// ==== source/irq_pending_reg.sv ====
/*
  Pending register. mip follows irq_i one cycle later with reserved lines
  forced to zero. Inputs are assumed synchronous to clk_i.
*/
`timescale 1ns/1ns
`default_nettype none

module irq_pending_reg (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic [irq_sleep_pkg::NUM_IRQ-1:0] irq_i,
  input  wire logic [irq_sleep_pkg::NUM_IRQ-1:0] mie_i,
  output logic      [irq_sleep_pkg::NUM_IRQ-1:0] mip_o,
  output logic      [irq_sleep_pkg::NUM_IRQ-1:0] pend_en_o
);

  logic [irq_sleep_pkg::NUM_IRQ-1:0] mip_q;
  logic [irq_sleep_pkg::NUM_IRQ-1:0] mip_d;

  // Reserved lines never reach the register
  assign mip_d = irq_i & irq_sleep_pkg::VALID_IRQ_MASK;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= mip_d;
    end
  end

  assign mip_o = mip_q;

  // Shared by the arbiter and the wake logic
  assign pend_en_o = mip_q & mie_i;

endmodule

`default_nettype wire

// ==== source/irq_prio_arb.sv ====
/*
  Fixed-priority interrupt arbiter with a registered, single-cycle ack.
  Order is lines 31..16, then 11, 3, 7. The cycle after an ack never acks,
  so a held line is acked at most every other cycle.
*/
`timescale 1ns/1ns
`default_nettype none

module irq_prio_arb (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic [irq_sleep_pkg::NUM_IRQ-1:0] pend_en_i,
  input  wire irq_sleep_pkg::csr_state_t         csr_i,
  output irq_sleep_pkg::irq_ack_t                irq_ack_o
);

  logic                               win_valid;
  logic [irq_sleep_pkg::IRQ_ID_W-1:0] win_id;
  logic                               take_m;
  logic                               take_u;
  logic                               take;
  logic                               ack_d;
  logic                               ack_q;
  logic [irq_sleep_pkg::IRQ_ID_W-1:0] id_q;

  // --------------------------------------------------------------------------
  // Winner selection
  // --------------------------------------------------------------------------
  // Lowest priority is assigned first so later matches override it
  always_comb begin
    win_id    = '0;
    win_valid = |pend_en_i;
    if (pend_en_i[7]) begin
      win_id = 5'd7;
    end
    if (pend_en_i[3]) begin
      win_id = 5'd3;
    end
    if (pend_en_i[11]) begin
      win_id = 5'd11;
    end
    for (int i = 16; i < irq_sleep_pkg::NUM_IRQ; i++) begin
      if (pend_en_i[i]) begin
        win_id = i[irq_sleep_pkg::IRQ_ID_W-1:0];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Take condition
  // --------------------------------------------------------------------------
  // U-mode traps to M-mode regardless of mstatus.MIE
  assign take_m = (csr_i.priv_lvl == irq_sleep_pkg::PRIV_LVL_M) && csr_i.mstatus_mie;
  assign take_u = (csr_i.priv_lvl == irq_sleep_pkg::PRIV_LVL_U) && (|pend_en_i);
  assign take   = take_m || take_u;

  assign ack_d = win_valid && take && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      id_q  <= '0;
    end else begin
      ack_q <= ack_d;
      id_q  <= win_id;
    end
  end

  assign irq_ack_o.ack = ack_q;
  assign irq_ack_o.id  = id_q;

endmodule

`default_nettype wire

// ==== source/irq_sleep_ctrl.sv ====
/*
  Machine-mode interrupt and sleep controller top level. Both OBI sides
  are only observed. All inputs are synchronous to clk_i.
*/
`timescale 1ns/1ns
`default_nettype none

module irq_sleep_ctrl (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic [irq_sleep_pkg::NUM_IRQ-1:0] irq_i,
  input  wire irq_sleep_pkg::csr_state_t         csr_i,
  input  wire irq_sleep_pkg::wb_instr_t          wb_i,
  input  wire irq_sleep_pkg::obi_mon_t           obi_iside_i,
  input  wire irq_sleep_pkg::obi_mon_t           obi_dside_i,
  input  wire logic                              wbuf_empty_i,
  input  wire logic                              debug_req_i,
  input  wire logic                              pending_nmi_i,
  input  wire logic                              wu_wfe_i,
  output logic      [irq_sleep_pkg::NUM_IRQ-1:0] mip_o,
  output irq_sleep_pkg::irq_ack_t                irq_ack_o,
  output logic                                   core_sleep_o,
  output logic                                   wb_retire_o
);

  logic [irq_sleep_pkg::NUM_IRQ-1:0] pend_en;
  logic                              iside_busy;
  logic                              dside_busy;

  // --------------------------------------------------------------------------
  // Interrupt path
  // --------------------------------------------------------------------------
  irq_pending_reg u_pending (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_i     (irq_i),
    .mie_i     (csr_i.mie),
    .mip_o     (mip_o),
    .pend_en_o (pend_en)
  );

  irq_prio_arb u_arb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .pend_en_i (pend_en),
    .csr_i     (csr_i),
    .irq_ack_o (irq_ack_o)
  );

  // --------------------------------------------------------------------------
  // Bus activity
  // --------------------------------------------------------------------------
  obi_outstanding_cnt u_iside_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .obi_i  (obi_iside_i),
    .busy_o (iside_busy)
  );

  obi_outstanding_cnt u_dside_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .obi_i  (obi_dside_i),
    .busy_o (dside_busy)
  );

  // --------------------------------------------------------------------------
  // Sleep control
  // --------------------------------------------------------------------------
  wfi_sleep_fsm u_sleep (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_i          (wb_i),
    .csr_i         (csr_i),
    .pend_en_i     (pend_en),
    .iside_busy_i  (iside_busy),
    .dside_busy_i  (dside_busy),
    .wbuf_empty_i  (wbuf_empty_i),
    .debug_req_i   (debug_req_i),
    .pending_nmi_i (pending_nmi_i),
    .wu_wfe_i      (wu_wfe_i),
    .core_sleep_o  (core_sleep_o),
    .wb_retire_o   (wb_retire_o)
  );

endmodule

`default_nettype wire

// ==== source/irq_sleep_pkg.sv ====
/*
  Shared widths, masks, encodings and bundle types of the interrupt and
  sleep controller. Interrupt lines 31..16, 11, 7 and 3 are the only ones
  implemented, and all others read as zero.
*/
`default_nettype none

package irq_sleep_pkg;

  // --------------------------------------------------------------------------
  // Widths and constants
  // --------------------------------------------------------------------------
  localparam int unsigned NUM_IRQ  = 32;
  localparam int unsigned IRQ_ID_W = 5;

  // Platform lines 31..16 plus MEI (11), MTI (7) and MSI (3)
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;
  localparam logic [31:0] WFE_INSTR = 32'h8c00_0073;

  // Writeback cycles a sleep instruction spends before sleep may start
  localparam int unsigned WFI_ENTRY_CYCLES = 2;

  localparam int unsigned OBI_CNT_W = 4;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // CSR view needed by the arbiter and the sleep FSM
  typedef struct packed {
    logic [NUM_IRQ-1:0] mie;
    logic               mstatus_mie;
    logic               mstatus_tw;
    priv_lvl_e          priv_lvl;
    logic               debug_mode;
  } csr_state_t;

  // Instruction currently held in writeback
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic        err;
    logic        kill;
  } wb_instr_t;

  // One OBI side as seen by a passive observer
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
  } obi_mon_t;

  typedef struct packed {
    logic                ack;
    logic [IRQ_ID_W-1:0] id;
  } irq_ack_t;

endpackage

`default_nettype wire

// ==== source/obi_outstanding_cnt.sv ====
/*
  Passive outstanding-beat counter for one OBI side. A beat starts on
  req && gnt and ends on rvalid. The count saturates at both limits, and
  busy stays high one cycle after the count drains.
*/
`timescale 1ns/1ns
`default_nettype none

module obi_outstanding_cnt (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire irq_sleep_pkg::obi_mon_t obi_i,
  output logic                         busy_o
);

  logic [irq_sleep_pkg::OBI_CNT_W-1:0] cnt_q;
  logic                                start;
  logic                                done;
  logic                                drain_q;

  assign start = obi_i.req && obi_i.gnt;
  assign done  = obi_i.rvalid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start && !done && (cnt_q != '1)) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!start && done && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // One cycle of hysteresis after the last response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      drain_q <= 1'b0;
    end else begin
      drain_q <= |cnt_q;
    end
  end

  assign busy_o = (|cnt_q) || drain_q;

endmodule

`default_nettype wire

// ==== source/wfi_sleep_fsm.sv ====
/*
  WFI/WFE sleep FSM. The instruction must stay in writeback until
  wb_retire_o or kill. Sleep starts after two writeback cycles once both
  bus sides and the write buffer are idle; a blocked WFI waits without bound.
*/
`timescale 1ns/1ns
`default_nettype none

module wfi_sleep_fsm (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire irq_sleep_pkg::wb_instr_t          wb_i,
  input  wire irq_sleep_pkg::csr_state_t         csr_i,
  input  wire logic [irq_sleep_pkg::NUM_IRQ-1:0] pend_en_i,
  input  wire logic                              iside_busy_i,
  input  wire logic                              dside_busy_i,
  input  wire logic                              wbuf_empty_i,
  input  wire logic                              debug_req_i,
  input  wire logic                              pending_nmi_i,
  input  wire logic                              wu_wfe_i,
  output logic                                   core_sleep_o,
  output logic                                   wb_retire_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    SLEEP
  } state_e;

  typedef logic [$clog2(irq_sleep_pkg::WFI_ENTRY_CYCLES + 1)-1:0] entry_cnt_t;

  state_e     state_q;
  state_e     state_d;
  entry_cnt_t cnt_q;
  entry_cnt_t cnt_d;
  logic       is_wfi;
  logic       is_wfe;
  logic       instr_ok;
  logic       sleep_instr;
  logic       blocked;
  logic       wake;
  logic       entry_done;

  // --------------------------------------------------------------------------
  // Instruction recognition
  // --------------------------------------------------------------------------
  assign is_wfi = wb_i.rdata == irq_sleep_pkg::WFI_INSTR;
  assign is_wfe = wb_i.rdata == irq_sleep_pkg::WFE_INSTR;

  // U-mode with TW set traps instead of sleeping
  assign instr_ok = wb_i.valid && !wb_i.err && !wb_i.kill && !csr_i.debug_mode &&
                    !((csr_i.priv_lvl == irq_sleep_pkg::PRIV_LVL_U) && csr_i.mstatus_tw);

  assign sleep_instr = instr_ok && (is_wfi || is_wfe);

  assign blocked = iside_busy_i || dside_busy_i || !wbuf_empty_i;

  // wu_wfe_i only wakes a WFE
  assign wake = (|pend_en_i) || debug_req_i || pending_nmi_i || (wu_wfe_i && is_wfe);

  assign entry_done = cnt_q == entry_cnt_t'(irq_sleep_pkg::WFI_ENTRY_CYCLES - 1);

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      IDLE: begin
        if (sleep_instr) begin
          state_d = WAIT;
          cnt_d   = entry_cnt_t'(1);
        end
      end
      WAIT: begin
        if (!sleep_instr || wake) begin
          state_d = IDLE;
        end else if (!entry_done) begin
          cnt_d = cnt_q + 1'b1;
        end else if (!blocked) begin
          state_d = SLEEP;
        end
      end
      SLEEP: begin
        if (!sleep_instr || wake) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------
  // Wake drops sleep in the same cycle, before the state register follows
  assign core_sleep_o = (state_q == SLEEP) && !wake;

  assign wb_retire_o = (state_q != IDLE) && sleep_instr && wake;

endmodule

`default_nettype wire

// ==== tb.f ====
source/irq_sleep_pkg.sv
source/irq_pending_reg.sv
source/irq_prio_arb.sv
source/obi_outstanding_cnt.sv
source/wfi_sleep_fsm.sv
source/irq_sleep_ctrl.sv
verif/irq_sleep_ctrl_asserts.sv
verif/tb_irq_sleep_ctrl.sv

// ==== verif/irq_sleep_ctrl_asserts.sv ====
/*
  Protocol assertions bound into the controller top level. They also
  observe the internal pending-and-enabled lines.
*/
`timescale 1ns/1ns
`default_nettype none

module irq_sleep_ctrl_asserts (
  input wire logic                              clk_i,
  input wire logic                              rst_ni,
  input wire irq_sleep_pkg::irq_ack_t           irq_ack_i,
  input wire logic                              core_sleep_i,
  input wire irq_sleep_pkg::wb_instr_t          wb_i,
  input wire logic [irq_sleep_pkg::NUM_IRQ-1:0] pend_en_i,
  input wire logic                              debug_req_i,
  input wire logic                              pending_nmi_i,
  input wire logic                              wu_wfe_i
);

  logic wake;

  // wu_wfe_i counts only while a WFE is in writeback
  assign wake = (|pend_en_i) || debug_req_i || pending_nmi_i ||
                (wu_wfe_i && (wb_i.rdata == irq_sleep_pkg::WFE_INSTR));

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i.ack |=> !irq_ack_i.ack)
    else $error("Interrupt ack high on two consecutive cycles");

  ack_id_implemented: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i.ack |-> irq_sleep_pkg::VALID_IRQ_MASK[irq_ack_i.id])
    else $error("Interrupt ack carries a reserved line id");

  sleep_without_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_i |-> !wake)
    else $error("Core sleep asserted while a wake source is present");

endmodule

bind irq_sleep_ctrl irq_sleep_ctrl_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .irq_ack_i     (irq_ack_o),
  .core_sleep_i  (core_sleep_o),
  .wb_i          (wb_i),
  .pend_en_i     (pend_en),
  .debug_req_i   (debug_req_i),
  .pending_nmi_i (pending_nmi_i),
  .wu_wfe_i      (wu_wfe_i)
);

`default_nettype wire

// ==== verif/tb_irq_sleep_ctrl.sv ====
/*
  Testbench for the interrupt and sleep controller. Concurrent assertions
  compare the DUT against a reference model kept here. The instruction-side
  bus stays idle throughout, so only the data side is modelled.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_irq_sleep_ctrl;

  localparam int unsigned RST_CYCLES  = 16;
  localparam int unsigned NUM_TESTS   = 6;
  localparam int unsigned TEST_LEN    = 60;
  localparam int unsigned WAIT_LIMIT  = 10;
  localparam int unsigned WATCHDOG_NS = (RST_CYCLES + NUM_TESTS * TEST_LEN + 100) * 40;

  logic                      clk_i;
  logic                      rst_ni;
  logic [31:0]               irq_i;
  irq_sleep_pkg::csr_state_t csr_i;
  irq_sleep_pkg::wb_instr_t  wb_i;
  irq_sleep_pkg::obi_mon_t   obi_iside_i;
  irq_sleep_pkg::obi_mon_t   obi_dside_i;
  logic                      wbuf_empty_i;
  logic                      debug_req_i;
  logic                      pending_nmi_i;
  logic                      wu_wfe_i;
  logic [31:0]               mip_o;
  irq_sleep_pkg::irq_ack_t   irq_ack_o;
  logic                      core_sleep_o;
  logic                      wb_retire_o;

  int          errors;
  int          tests;
  logic [31:0] lcg_state;

  // Reference model
  logic [31:0] mip_ref;
  logic [31:0] pe_ref;
  logic        take_ref;
  logic        ack_ref;
  logic [4:0]  id_ref;
  logic        recog;
  logic        wake_ref;
  logic        blocked_ref;
  logic [3:0]  dcnt_ref;
  logic        ddrain_ref;
  int unsigned age;

  irq_sleep_ctrl irq_sleep_ctrl_i (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Highest line of 31..16 first, then 11, 3 and 7
  function automatic logic [4:0] prio_winner(input logic [31:0] pe);
    for (int i = 31; i >= 16; i--) begin
      if (pe[i]) return 5'(i);
    end
    if (pe[11]) return 5'd11;
    if (pe[3]) return 5'd3;
    return 5'd7;
  endfunction

  assign pe_ref   = mip_ref & csr_i.mie;
  assign take_ref = ((csr_i.priv_lvl == irq_sleep_pkg::PRIV_LVL_M) && csr_i.mstatus_mie) ||
                    ((csr_i.priv_lvl == irq_sleep_pkg::PRIV_LVL_U) && (|pe_ref));
  assign recog    = wb_i.valid && !wb_i.err && !wb_i.kill && !csr_i.debug_mode &&
                    ((wb_i.rdata == irq_sleep_pkg::WFI_INSTR) ||
                     (wb_i.rdata == irq_sleep_pkg::WFE_INSTR)) &&
                    !((csr_i.priv_lvl == irq_sleep_pkg::PRIV_LVL_U) && csr_i.mstatus_tw);
  assign wake_ref = (|pe_ref) || debug_req_i || pending_nmi_i ||
                    (wu_wfe_i && (wb_i.rdata == irq_sleep_pkg::WFE_INSTR));
  assign blocked_ref = (dcnt_ref != 4'd0) || ddrain_ref || !wbuf_empty_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_ref    <= '0;
      ack_ref    <= 1'b0;
      id_ref     <= '0;
      dcnt_ref   <= '0;
      ddrain_ref <= 1'b0;
      age        <= 0;
    end else begin
      mip_ref    <= irq_i & irq_sleep_pkg::VALID_IRQ_MASK;
      ack_ref    <= (|pe_ref) && take_ref && !ack_ref;
      id_ref     <= prio_winner(pe_ref);
      dcnt_ref   <= dcnt_ref + 4'(obi_dside_i.req && obi_dside_i.gnt) - 4'(obi_dside_i.rvalid);
      ddrain_ref <= dcnt_ref != 4'd0;
      age        <= recog ? age + 1 : 0;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic report_err(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  a_mip: assert property (@(posedge clk_i) disable iff (!rst_ni) mip_o == mip_ref)
    else report_err("mip_o is not the masked irq_i of the previous cycle");
  a_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) irq_ack_o.ack == ack_ref)
    else report_err("ack does not follow the pending lines and take condition");
  a_ack_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_ref |-> irq_ack_o.id == id_ref)
    else report_err("ack id is not the priority winner");
  a_no_ack_mie: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((csr_i.priv_lvl == irq_sleep_pkg::PRIV_LVL_M) && !csr_i.mstatus_mie) |=> !irq_ack_o.ack)
    else report_err("ack taken in M-mode with mstatus.MIE clear");
  a_sleep_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o |-> recog && !wake_ref)
    else report_err("core sleep without a sleep instruction or during a wake");
  a_sleep_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (recog && (age >= 1) && !blocked_ref && !wake_ref) ##1 (recog && !wake_ref) |-> core_sleep_o)
    else report_err("core sleep missing after entry wait");
  a_sleep_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(core_sleep_o) |-> $past(recog && !blocked_ref && (age >= 1)))
    else report_err("core sleep rose early or while blocked");
  a_sleep_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o ##1 (recog && !wake_ref) |-> core_sleep_o)
    else report_err("core sleep dropped without a wake source");
  a_wake_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o ##1 (recog && wake_ref) |-> wb_retire_o && !core_sleep_o)
    else report_err("wake did not retire the sleep instruction");
  a_retire_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_retire_o |-> recog && wake_ref)
    else report_err("retire without a held sleep instruction and a wake");

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  task automatic step(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #5;
    end
  endtask

  // Looks mid-cycle for sleep or retire, then moves to the next drive point
  task automatic wait_for(input bit retire, input string what);
    bit seen;
    seen = 1'b0;
    for (int n = 0; (n < WAIT_LIMIT) && !seen; n++) begin
      @(negedge clk_i);
      seen = retire ? wb_retire_o : core_sleep_o;
    end
    if (!seen) begin
      $display("Timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
      errors++;
    end
    step(1);
  endtask

  task automatic present(input logic [31:0] instr);
    wb_i.valid = 1'b1;
    wb_i.rdata = instr;
    wb_i.err   = 1'b0;
    wb_i.kill  = 1'b0;
  endtask

  task automatic ack_case(input logic [31:0] lines);
    irq_i = lines;
    step(3);
    irq_i = '0;
    step(2);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d (%s) finished, errors so far %0d", tests, name, errors);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Errors found");
    $finish;
  end

  initial begin
    errors              = 0;
    tests               = 0;
    lcg_state           = 32'he155;
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    irq_i               = '0;
    csr_i               = '0;
    csr_i.priv_lvl      = irq_sleep_pkg::PRIV_LVL_M;
    csr_i.mstatus_mie   = 1'b1;
    wb_i                = '0;
    obi_iside_i         = '0;
    obi_dside_i         = '0;
    wbuf_empty_i        = 1'b1;
    debug_req_i         = 1'b0;
    pending_nmi_i       = 1'b0;
    wu_wfe_i            = 1'b0;
    step(RST_CYCLES);
    rst_ni = 1'b1;
    step(2);

    // Random lines and enables with the LCG halves swapped so low lines see upper bits
    for (int n = 0; n < 40; n++) begin
      lcg_state = lcg_next(lcg_state);
      irq_i     = {lcg_state[15:0], lcg_state[31:16]};
      lcg_state = lcg_next(lcg_state);
      csr_i.mie = lcg_state;
      step(1);
    end
    irq_i     = '0;
    csr_i.mie = '0;
    step(2);
    end_test("random mip and ack");

    csr_i.mie = '1;
    ack_case(32'h0000_0888);
    ack_case(32'h0000_0088);
    ack_case(32'h0000_0080);
    ack_case(32'h0001_0808);
    ack_case(32'h8000_0000);
    ack_case(32'h0000_7777);
    end_test("ack priority");

    csr_i.mstatus_mie = 1'b0;
    irq_i             = 32'h0000_0888;
    step(4);
    csr_i.mstatus_mie = 1'b1;
    csr_i.mie         = '0;
    step(4);
    irq_i = '0;
    step(2);
    end_test("ack masked");

    // Sleep tests run with interrupts globally off so wakes raise no ack
    csr_i.mstatus_mie = 1'b0;
    present(irq_sleep_pkg::WFI_INSTR);
    wait_for(1'b0, "core sleep");
    step(3);
    csr_i.mie[11] = 1'b1;
    irq_i[11]     = 1'b1;
    wait_for(1'b1, "retire on interrupt");
    wb_i.valid = 1'b0;
    irq_i      = '0;
    csr_i.mie  = '0;
    step(2);
    end_test("wfi sleep and interrupt wake");

    obi_dside_i.req = 1'b1;
    obi_dside_i.gnt = 1'b1;
    present(irq_sleep_pkg::WFI_INSTR);
    step(1);
    obi_dside_i = '0;
    step(6);
    obi_dside_i.rvalid = 1'b1;
    step(1);
    obi_dside_i.rvalid = 1'b0;
    wait_for(1'b0, "core sleep after rvalid");
    debug_req_i = 1'b1;
    wait_for(1'b1, "retire on debug request");
    wb_i.valid  = 1'b0;
    debug_req_i = 1'b0;
    step(2);
    csr_i.priv_lvl   = irq_sleep_pkg::PRIV_LVL_U;
    csr_i.mstatus_tw = 1'b1;
    present(irq_sleep_pkg::WFI_INSTR);
    step(8);
    wb_i.valid       = 1'b0;
    csr_i.priv_lvl   = irq_sleep_pkg::PRIV_LVL_M;
    csr_i.mstatus_tw = 1'b0;
    step(2);
    end_test("blocked and trapped wfi");

    present(irq_sleep_pkg::WFE_INSTR);
    wait_for(1'b0, "core sleep on wfe");
    step(2);
    wu_wfe_i = 1'b1;
    wait_for(1'b1, "retire on wfe wakeup");
    wb_i.valid = 1'b0;
    wu_wfe_i   = 1'b0;
    step(2);
    present(irq_sleep_pkg::WFI_INSTR);
    wait_for(1'b0, "core sleep on wfi");
    wu_wfe_i = 1'b1;
    step(3);
    pending_nmi_i = 1'b1;
    wait_for(1'b1, "retire on nmi");
    wb_i.valid    = 1'b0;
    wu_wfe_i      = 1'b0;
    pending_nmi_i = 1'b0;
    step(2);
    end_test("wfe wakeup");

    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
